// File: bench/interact_testdata.txt
# Fields hex: W addr data, R addr expected, T src(0 tape 1 line) count, L count, E name
# F vid_addr line half blank red green blue is queued, X issues queued fetches back to back
# After reset
R 1000 FF
R 1800 FF
R 3000 00
E reset
# Random RAM fill, unmapped and sound regions
L 40
R 0000 FF
R 3800 FF
R 8000 FF
W 4123 5A
W 2000 00
W 2800 00
W 2123 11
R 4123 5A
R 2000 FF
R 2800 FF
E ram
# RTC with tape source in flux mode, then line source in full mode
W 3000 38
T 0 85
R 3000 05
T 1 10
R 3000 05
W 3000 78
R 3000 00
W 3000 B8
T 1 C3
R 3000 C3
T 1 40
R 3000 03
W 3000 B0
R 3000 00
W 3000 B8
R 3000 03
E rtc
# Pixel codes, byte E4 at 010 and 1B at 7FF
W 4010 E4
W 47FF 1B
W 1000 2C
W 1800 1A
F 010 0 0 0 00 00 FF
X
F 010 0 1 0 00 FF 00
X
F 010 1 0 0 FF 00 FF
X
F 010 1 1 0 FF FF 00
X
F 7FF 0 0 0 FF FF 00
F 7FF 0 1 0 FF 00 FF
F 7FF 1 0 0 00 FF 00
F 7FF 1 1 0 00 00 FF
X
E pixel
# Intensity, blanking and back-to-back fetches
W 1800 5A
F 010 1 0 0 7F 00 7F
X
F 010 1 1 1 00 00 00
X
F 010 1 0 0 7F 00 7F
F 010 1 0 1 00 00 00
F 7FF 0 0 0 FF FF 00
F 7FF 1 1 0 00 00 FF
X
E timing

// File: bench/tb_clock.sv
// Clock and reset source for the testbench
`timescale 1ns/1ns
`default_nettype none

module tb_clock
(
	output logic clk_sys,
	output logic rst_n
);

	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 16;

	initial
	begin
		clk_sys = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Release a little after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge clk_sys);
		#10;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/tb_interact_io.sv
// Testbench for the I/O and pixel colour path
// Operations from the data file, LFSR data for RAM fill, watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_interact_io;

	localparam int PERIOD_NS = 100;
	localparam int DRIVE_NS  = 10;

	typedef struct packed
	{
		logic [7:0]       code;
		logic [6:0][15:0] f;
		logic [8*16-1:0]  name;
	} op_t;

	logic        clk_sys;
	logic        rst_n;
	logic [15:0] bus_addr;
	logic [7:0]  bus_wdata;
	logic        bus_wr;
	logic        bus_rd;
	logic [7:0]  bus_rdata;
	logic        line_tick;
	logic        tape_tick;
	logic        vid_fetch;
	logic [11:0] vid_addr;
	logic        vid_line;
	logic        vid_half;
	logic        vid_blank;
	logic [7:0]  red;
	logic [7:0]  green;
	logic [7:0]  blue;
	logic        rgb_valid;

	op_t         ops[$];
	op_t         fetch_q[$];
	logic [13:0] fill_q[$];
	logic [7:0]  ram_model [0:16383];
	logic [31:0] lfsr;
	int          tests = 0;
	int          checks = 0;
	int          errors = 0;
	int          test_checks = 0;
	int          test_errors = 0;
	longint      limit_ns = 0;

	tb_clock u_clock
	(
		.clk_sys (clk_sys),
		.rst_n   (rst_n)
	);

	interact_io_top uut
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_wr    (bus_wr),
		.bus_rd    (bus_rd),
		.bus_rdata (bus_rdata),
		.line_tick (line_tick),
		.tape_tick (tape_tick),
		.vid_fetch (vid_fetch),
		.vid_addr  (vid_addr),
		.vid_line  (vid_line),
		.vid_half  (vid_half),
		.vid_blank (vid_blank),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.rgb_valid (rgb_valid)
	);

	// ==============================
	// Helpers
	// ==============================

	// Galois form, taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s >> 1;
		if (s[0])
			lfsr_next = lfsr_next ^ 32'hA300_0000;
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		checks++;
		test_checks++;
		if (actual !== expected)
		begin
			errors++;
			test_errors++;
			$display("Error at %0t ns: %0s, got %h, expected %h", $time, msg, actual, expected);
		end
	endtask

	// ==============================
	// Bus and video drivers
	// ==============================

	// All drivers start and end on a rising edge
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		#DRIVE_NS;
		bus_addr  = addr;
		bus_wdata = data;
		bus_wr    = 1'b1;
		@(posedge clk_sys);
		#DRIVE_NS;
		bus_wr = 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic [7:0] expected);
		#DRIVE_NS;
		bus_addr = addr;
		bus_rd   = 1'b1;
		@(posedge clk_sys);
		#DRIVE_NS;
		bus_rd = 1'b0;
		@(negedge clk_sys);
		compare(bus_rdata, expected, $sformatf("read at %h", addr));
		compare(rgb_valid, 1'b0, "rgb_valid high with no fetch in flight");
		@(posedge clk_sys);
	endtask

	task automatic pulse_ticks(input logic use_line, input int n);
		for (int i = 0; i < n; i++)
		begin
			#DRIVE_NS;
			line_tick = use_line;
			tape_tick = !use_line;
			@(posedge clk_sys);
			#DRIVE_NS;
			line_tick = 1'b0;
			tape_tick = 1'b0;
			@(posedge clk_sys);
		end
	endtask

	// Issue queued fetches back to back, result due 2 cycles after each
	task automatic run_fetches();
		int  n;
		op_t e;
		n = fetch_q.size();
		for (int c = 0; c < n + 3; c++)
		begin
			#DRIVE_NS;
			vid_fetch = (c < n);
			if (c < n)
			begin
				vid_addr  = fetch_q[c].f[0][11:0];
				vid_line  = fetch_q[c].f[1][0];
				vid_half  = fetch_q[c].f[2][0];
				vid_blank = fetch_q[c].f[3][0];
			end
			@(negedge clk_sys);
			if (c >= 2 && c - 2 < n)
			begin
				e = fetch_q[c - 2];
				compare({rgb_valid, red, green, blue},
					{1'b1, e.f[4][7:0], e.f[5][7:0], e.f[6][7:0]},
					$sformatf("fetch %0d at %h, valid and RGB", c - 2, e.f[0][11:0]));
			end
			else
				compare(rgb_valid, 1'b0, "rgb_valid outside a result slot");
			@(posedge clk_sys);
		end
		fetch_q.delete();
	endtask

	task automatic random_fill(input int n);
		logic [31:0] a;
		logic [31:0] d;
		fill_q.delete();
		for (int i = 0; i < n; i++)
		begin
			random_bits(14, a);
			random_bits(8, d);
			ram_model[a[13:0]] = d[7:0];
			fill_q.push_back(a[13:0]);
			bus_write({2'b01, a[13:0]}, d[7:0]);
		end
		foreach (fill_q[i])
			bus_read({2'b01, fill_q[i]}, ram_model[fill_q[i]]);
	endtask

	// ==============================
	// Data file and sequencing
	// ==============================

	task automatic load_ops(output int ok);
		int              fd;
		int              code;
		logic [7:0]      op;
		logic [15:0]     v [0:6];
		logic [8*16-1:0] name;
		logic [1023:0]   rest;
		op_t             o;
		fd = $fopen("bench/interact_testdata.txt", "r");
		ok = (fd != 0);
		if (ok)
		begin
			while ($fscanf(fd, " %c", op) == 1)
			begin
				foreach (v[i])
					v[i] = '0;
				name = '0;
				case (op)
					"#": code = $fgets(rest, fd);
					"W", "R", "T": code = $fscanf(fd, "%h %h", v[0], v[1]);
					"F": code = $fscanf(fd, "%h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
					"L": code = $fscanf(fd, "%h", v[0]);
					"E": code = $fscanf(fd, "%s", name);
					default: code = 0;
				endcase
				o.code = op;
				o.name = name;
				for (int i = 0; i < 7; i++)
					o.f[i] = v[i];
				if (op != "#")
					ops.push_back(o);
			end
			$fclose(fd);
		end
	endtask

	// Lines times the longest operation, plus margin for reset
	function automatic longint run_limit();
		int len;
		int max_len;
		int queued;
		max_len = 1;
		queued  = 0;
		foreach (ops[i])
		begin
			case (ops[i].code)
				"W", "R": len = 2;
				"T": len = 2 * ops[i].f[1];
				"L": len = 4 * ops[i].f[0];
				"F":
				begin
					len = 0;
					queued++;
				end
				"X":
				begin
					len = queued + 3;
					queued = 0;
				end
				default: len = 0;
			endcase
			if (len > max_len)
				max_len = len;
		end
		run_limit = longint'(ops.size()) * max_len * PERIOD_NS + 200 * PERIOD_NS;
	endfunction

	task automatic end_test(input logic [8*16-1:0] name);
		tests++;
		$display("Test %0s: %0d checks, %0d errors, %0s", name, test_checks, test_errors,
			(test_errors == 0) ? "ok" : "FAILED");
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic run_op(input op_t o);
		case (o.code)
			"W": bus_write(o.f[0], o.f[1][7:0]);
			"R": bus_read(o.f[0], o.f[1][7:0]);
			"T": pulse_ticks(o.f[0][0], o.f[1]);
			"F": fetch_q.push_back(o);
			"X": run_fetches();
			"L": random_fill(o.f[0]);
			"E": end_test(o.name);
			default:
			begin
				errors++;
				$display("Unknown operation '%c' in the test data", o.code);
			end
		endcase
	endtask

	initial
	begin
		int ok;
		bus_addr  = '0;
		bus_wdata = '0;
		bus_wr    = 1'b0;
		bus_rd    = 1'b0;
		line_tick = 1'b0;
		tape_tick = 1'b0;
		vid_fetch = 1'b0;
		vid_addr  = '0;
		vid_line  = 1'b0;
		vid_half  = 1'b0;
		vid_blank = 1'b0;
		lfsr      = 32'hC494_A91B;
		load_ops(ok);
		if (!ok)
		begin
			$display("Could not open the test data file");
			$display("STATUS: FAIL");
			$finish;
		end
		else
		begin
			limit_ns = run_limit();
			wait (rst_n === 1'b1);
			@(posedge clk_sys);
			foreach (ops[i])
				run_op(ops[i]);
			$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
			if (errors == 0 && checks > 0)
				$display("STATUS: PASS");
			else
				$display("STATUS: FAIL");
			$finish;
		end
	end

	// Watchdog
	initial
	begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("Run timed out after %0d ns, an operation never completed", limit_ns);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/bus_decode.sv
// CPU address decoding into write strobes
// Read source selection and bus_rdata holding register
`timescale 1ns/1ns
`default_nettype none

module bus_decode import interact_pkg::*;
(
	input  logic  clk_sys,
	input  logic  rst_n,
	input  addr_t bus_addr,
	input  data_t bus_wdata,
	input  logic  bus_wr,
	input  logic  bus_rd,
	input  data_t cpu_rdata,
	input  data_t rtc_rdata,
	output data_t bus_rdata,
	io_bus_if.decoder io
);

	logic       in_io;
	logic       in_ram;
	logic [2:0] region;
	logic       rd_ram_d;
	logic       rd_rtc_d;
	logic       rd_pend;
	logic       rd_ram;
	logic       rd_rtc;
	data_t      rd_sel;
	data_t      rdata_q;

	// ==============================
	// Address split
	// ==============================

	assign in_io  = (bus_addr[15:14] == 2'b00);
	assign in_ram = (bus_addr[15:14] == 2'b01);
	assign region = bus_addr[13:11];

	// Sound regions 2000H and 2800H get no strobe
	assign io.wr_col_a = bus_wr && in_io && (region == REGION_COL_A);
	assign io.wr_col_b = bus_wr && in_io && (region == REGION_COL_B);
	assign io.wr_misc  = bus_wr && in_io && (region == REGION_MISC);
	assign io.ram_wr   = bus_wr && in_ram;
	assign io.wdata    = bus_wdata;
	assign io.ram_addr = bus_addr[13:0];

	// Read source for the current address
	always_comb
	begin
		rd_ram_d = in_ram;
		rd_rtc_d = 1'b0;
		if (in_io)
		begin
			case (region)
				REGION_MISC: rd_rtc_d = 1'b1;
				// No boot ROM or keyboard behind these
				REGION_ROM, REGION_KEYS: rd_rtc_d = 1'b0;
				default: rd_rtc_d = 1'b0;
			endcase
		end
	end

	// ==============================
	// Read data path
	// ==============================

	// RAM data is registered, so the source is chosen one cycle later
	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_pend <= 1'b0;
			rd_ram  <= 1'b0;
			rd_rtc  <= 1'b0;
			rdata_q <= FILL_BYTE;
		end
		else
		begin
			rd_pend <= bus_rd;
			if (bus_rd)
			begin
				rd_ram <= rd_ram_d;
				rd_rtc <= rd_rtc_d;
			end
			// Keep the byte until the next read
			if (rd_pend)
				rdata_q <= rd_sel;
		end
	end

	assign rd_sel = rd_ram ? cpu_rdata : (rd_rtc ? rtc_rdata : FILL_BYTE);

	assign bus_rdata = rd_pend ? rd_sel : rdata_q;

	// One bus cycle is either a read or a write
	a_wr_rd_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!(bus_wr && bus_rd));

endmodule

`default_nettype wire

// File: hw/interact_io_top.sv
// Top level of the memory-mapped I/O and pixel colour path
// Connects decoder, registers, video RAM and pixel pipeline
`timescale 1ns/1ns
`default_nettype none

module interact_io_top import interact_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,

	// CPU bus
	input  addr_t     bus_addr,
	input  data_t     bus_wdata,
	input  logic      bus_wr,
	input  logic      bus_rd,
	output data_t     bus_rdata,

	// RTC tick sources
	input  logic      line_tick,
	input  logic      tape_tick,

	// Video timing
	input  logic      vid_fetch,
	input  vid_addr_t vid_addr,
	input  logic      vid_line,
	input  logic      vid_half,
	input  logic      vid_blank,

	// Colour output
	output chan_t     red,
	output chan_t     green,
	output chan_t     blue,
	output logic      rgb_valid
);

	data_t col_a;
	data_t col_b;
	data_t rtc_rdata;
	data_t cpu_rdata;
	data_t vid_rdata;

	io_bus_if io ();

	// ==============================
	// CPU side
	// ==============================

	bus_decode u_bus_decode
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_wr    (bus_wr),
		.bus_rd    (bus_rd),
		.cpu_rdata (cpu_rdata),
		.rtc_rdata (rtc_rdata),
		.bus_rdata (bus_rdata),
		.io        (io.decoder)
	);

	io_regs u_io_regs
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.line_tick (line_tick),
		.tape_tick (tape_tick),
		.io        (io.regs),
		.col_a     (col_a),
		.col_b     (col_b),
		.rtc_rdata (rtc_rdata)
	);

	video_ram u_video_ram
	(
		.clk_sys   (clk_sys),
		.vid_addr  (vid_addr),
		.io        (io.ram),
		.cpu_rdata (cpu_rdata),
		.vid_rdata (vid_rdata)
	);

	// ==============================
	// Video side
	// ==============================

	pixel_gen u_pixel_gen
	(
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.vid_fetch (vid_fetch),
		.vid_line  (vid_line),
		.vid_half  (vid_half),
		.vid_blank (vid_blank),
		.vid_rdata (vid_rdata),
		.col_a     (col_a),
		.col_b     (col_b),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.rgb_valid (rgb_valid)
	);

endmodule

`default_nettype wire

// File: hw/interact_pkg.sv
// Shared widths, vector types and bus address regions
// RTC readback mode patterns and RGB channel levels
`default_nettype none

package interact_pkg;

	// ==============================
	// Vector types
	// ==============================

	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;
	typedef logic [13:0] vram_addr_t;
	typedef logic [11:0] vid_addr_t;
	typedef logic [1:0]  pix_t;
	// bit0 red, bit1 green, bit2 blue
	typedef logic [2:0]  color_t;
	typedef logic [7:0]  chan_t;

	// ==============================
	// Address regions
	// ==============================

	// Address bits 13..11, only valid when bits 15..14 are 00
	localparam logic [2:0] REGION_ROM   = 3'd0;
	localparam logic [2:0] REGION_COL_A = 3'd2;
	localparam logic [2:0] REGION_COL_B = 3'd3;
	localparam logic [2:0] REGION_MISC  = 3'd6;
	localparam logic [2:0] REGION_KEYS  = 3'd7;

	// Read value of unmapped or absent devices
	localparam data_t FILL_BYTE = 8'hFF;

	// ==============================
	// RTC readback modes
	// ==============================

	// Patterns on misc bits 7..3, used as casez items
	localparam logic [4:0] RTC_MODE_FLUX = 5'b00111;
	localparam logic [4:0] RTC_MODE_FULL = 5'b10111;
	localparam logic [4:0] RTC_MODE_LOW  = 5'b?1111;

	// ==============================
	// Colour output
	// ==============================

	localparam chan_t LEVEL_FULL = 8'hFF;
	localparam chan_t LEVEL_HALF = 8'h7F;

	// Halves the level of pixel code 2 when set in colour B
	localparam int INTENSITY_BIT = 6;

endpackage

`default_nettype wire

// File: hw/io_bus_if.sv
// Decoded CPU write strobes, write data and RAM address
`timescale 1ns/1ns
`default_nettype none

interface io_bus_if import interact_pkg::*; ();

	// One-cycle strobes, bus_wr qualified by region
	logic       wr_col_a;
	logic       wr_col_b;
	logic       wr_misc;
	logic       ram_wr;

	data_t      wdata;
	vram_addr_t ram_addr;

	modport decoder
	(
		output wr_col_a, wr_col_b, wr_misc, ram_wr, wdata, ram_addr
	);

	modport regs
	(
		input wr_col_a, wr_col_b, wr_misc, wdata
	);

	// RAM reads at ram_addr every cycle
	modport ram
	(
		input ram_wr, wdata, ram_addr
	);

endinterface

`default_nettype wire

// File: hw/io_regs.sv
// Colour A, colour B and misc registers
// RTC counter with tick select, clear and mode-dependent readback
`timescale 1ns/1ns
`default_nettype none

module io_regs import interact_pkg::*;
(
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  line_tick,
	input  logic  tape_tick,
	io_bus_if.regs io,
	output data_t col_a,
	output data_t col_b,
	output data_t rtc_rdata
);

	data_t misc;
	data_t rtc;
	logic  rtc_tick;
	logic  rtc_clr;

	// ==============================
	// CPU registers
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
		begin
			col_a <= '0;
			col_b <= '0;
			misc  <= '0;
		end
		else
		begin
			if (io.wr_col_a)
				col_a <= io.wdata;
			if (io.wr_col_b)
				col_b <= io.wdata;
			if (io.wr_misc)
				misc <= io.wdata;
		end
	end

	// ==============================
	// RTC counter
	// ==============================

	// Line rate when misc bit 7 set, tape clock otherwise
	assign rtc_tick = misc[7] ? line_tick : tape_tick;
	assign rtc_clr  = misc[6];

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			rtc <= '0;
		else if (rtc_clr)
			rtc <= '0;
		else if (rtc_tick)
			rtc <= rtc + 8'd1;
	end

	// Readback format chosen by misc bits 7..3
	always_comb
	begin
		casez (misc[7:3])
			// Tape flux bit is not present and reads as 0
			RTC_MODE_FLUX: rtc_rdata = {1'b0, rtc[6:0]};
			RTC_MODE_FULL: rtc_rdata = rtc;
			RTC_MODE_LOW:  rtc_rdata = {1'b0, rtc[6:0]};
			// Joystick and paddle modes
			default:       rtc_rdata = 8'h00;
		endcase
	end

	// Clear bit holds the counter at zero from the next cycle on
	a_rtc_clear: assert property (@(posedge clk_sys) disable iff (!rst_n)
		misc[6] |=> (rtc == '0));

endmodule

`default_nettype wire

// File: hw/pixel_gen.sv
// Two-stage pixel pipeline
// Pixel code select, colour lookup with intensity, blanking
`timescale 1ns/1ns
`default_nettype none

module pixel_gen import interact_pkg::*;
(
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  vid_fetch,
	input  logic  vid_line,
	input  logic  vid_half,
	input  logic  vid_blank,
	input  data_t vid_rdata,
	input  data_t col_a,
	input  data_t col_b,
	output chan_t red,
	output chan_t green,
	output chan_t blue,
	output logic  rgb_valid
);

	logic       s1_valid;
	logic       s1_line;
	logic       s1_half;
	logic       s1_blank;
	logic [3:0] nib;
	pix_t       pix;
	color_t     color;
	chan_t      level;

	// ==============================
	// Stage 1, aligned with RAM read
	// ==============================

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= vid_fetch;
	end

	always_ff @(posedge clk_sys)
	begin
		s1_line  <= vid_line;
		s1_half  <= vid_half;
		s1_blank <= vid_blank;
	end

	// ==============================
	// Stage 2, colour lookup
	// ==============================

	// Upper nibble on line 1, then one pixel pair by half
	assign nib = s1_line ? vid_rdata[7:4] : vid_rdata[3:0];
	assign pix = s1_half ? nib[3:2] : nib[1:0];

	always_comb
	begin
		case (pix)
			2'd0:    color = col_a[2:0];
			2'd1:    color = col_b[2:0];
			2'd2:    color = col_a[5:3];
			default: color = col_b[5:3];
		endcase
	end

	// Intensity only affects code 2
	assign level = ((pix == 2'd2) && col_b[INTENSITY_BIT]) ? LEVEL_HALF : LEVEL_FULL;

	always_ff @(posedge clk_sys or negedge rst_n)
	begin
		if (!rst_n)
			rgb_valid <= 1'b0;
		else
			rgb_valid <= s1_valid;
	end

	// Channel values, held between fetches
	always_ff @(posedge clk_sys)
	begin
		if (s1_valid)
		begin
			red   <= (!s1_blank && color[0]) ? level : '0;
			green <= (!s1_blank && color[1]) ? level : '0;
			blue  <= (!s1_blank && color[2]) ? level : '0;
		end
	end

	// Blanked fetch comes out black two cycles later
	a_blank_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(vid_fetch && vid_blank) |-> ##2
		(rgb_valid && red == '0 && green == '0 && blue == '0));

endmodule

`default_nettype wire

// File: hw/video_ram.sv
// Dual-port video/CPU byte RAM
// CPU read-write port and video read port, both registered
`timescale 1ns/1ns
`default_nettype none

module video_ram import interact_pkg::*;
(
	input  logic      clk_sys,
	input  vid_addr_t vid_addr,
	io_bus_if.ram     io,
	output data_t     cpu_rdata,
	output data_t     vid_rdata
);

	localparam int DEPTH = 1 << $bits(vram_addr_t);
	localparam int PAD   = $bits(vram_addr_t) - $bits(vid_addr_t);

	data_t      mem [0:DEPTH-1];
	vram_addr_t vid_full;

	// Video sees only the bottom 4 KB
	assign vid_full = {{PAD{1'b0}}, vid_addr};

	// CPU port, read returns the old byte on a write
	always_ff @(posedge clk_sys)
	begin
		if (io.ram_wr)
			mem[io.ram_addr] <= io.wdata;
		cpu_rdata <= mem[io.ram_addr];
	end

	// Video port
	always_ff @(posedge clk_sys)
	begin
		vid_rdata <= mem[vid_full];
	end

	a_vid_addr_known: assert property (@(posedge clk_sys)
		!$isunknown(vid_addr));

endmodule

`default_nettype wire

// File: interact_io.f
hw/interact_pkg.sv
hw/io_bus_if.sv
hw/bus_decode.sv
hw/io_regs.sv
hw/video_ram.sv
hw/pixel_gen.sv
hw/interact_io_top.sv
bench/tb_clock.sv
bench/tb_interact_io.sv
